/* Bender.yml */
package:
  name: mips_pipeline

sources:
  - verilog/mips_pkg.sv
  - verilog/mips_fetch.sv
  - verilog/mips_regfile.sv
  - verilog/mips_decode.sv
  - verilog/mips_execute.sv
  - verilog/mips_memory.sv
  - verilog/mips_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/mips_top_tb.sv

/* list.f */
+incdir+include
verilog/mips_pkg.sv
verilog/mips_fetch.sv
verilog/mips_regfile.sv
verilog/mips_decode.sv
verilog/mips_execute.sv
verilog/mips_memory.sv
verilog/mips_top.sv
verification/mips_top_tb.sv

/* include/mips_tb_program.svh */
`ifndef MIPS_TB_PROGRAM_SVH
`define MIPS_TB_PROGRAM_SVH

localparam int PROG_WORDS = 28;

// one word per fetch address counted from RESET_PC
localparam logic [31:0] PROG_IMAGE [PROG_WORDS] = '{
    32'h24010080, 32'h24020005, 32'h344300F0, 32'h3C041234,
    32'h00832821, 32'h00A23023, 32'h00C33824, 32'h00E44025,
    32'h0048482A, 32'hAC250000, 32'hAC260004, 32'hAC280008,
    32'hAC29000C, 32'h00025023, 32'h004A582A, 32'hAC2B0010,
    32'h8C0C0004, 32'h258D0011, 32'hAC2D0014, 32'h8C0E0004,
    32'h11CC0002, 32'hAC220018, 32'hAC23001C, 32'h14420004,
    32'hAC240020, 32'hAC270024, 32'h1000FFFF, 32'h00000000
};

localparam int EXP_STORES = 9;

// stores in program order
localparam logic [31:0] EXP_ADDR [EXP_STORES] = '{
    32'h00000080, 32'h00000084, 32'h00000088, 32'h0000008C, 32'h00000090,
    32'h00000094, 32'h00000098, 32'h000000A0, 32'h000000A4
};

// for a load-based entry this is the addend to the preloaded word
localparam logic [31:0] EXP_DATA [EXP_STORES] = '{
    32'h123400F5, 32'h123400F0, 32'h123400F0, 32'h00000001, 32'h00000000,
    32'h00000011, 32'h00000005, 32'h12340000, 32'h000000F0
};

// preload word index or -1 where the value is fixed
localparam int EXP_LOAD_IDX [EXP_STORES] = '{-1, -1, -1, -1, -1, 1, -1, -1, -1};

`endif

/* verification/mips_top_tb.sv */
`timescale 1ns/1ps

module mips_top_tb
    import mips_pkg::*;
();

    `include "mips_tb_program.svh"

    localparam word_t RESET_PC      = 32'hBFC0_0000;
    localparam int    CLK_PERIOD    = 40;
    localparam int    STORE_TIMEOUT = 300;
    localparam int    DRAIN_CYCLES  = 40;
    localparam int    ADVANCE_SPAN  = 12;
    localparam word_t LFSR_TAPS     = 32'h8020_0003;

    logic       clk;
    logic       rst_n;
    word_t      inst_sram_addr;
    word_t      inst_sram_rdata;
    logic [3:0] data_sram_wen;
    word_t      data_sram_addr;
    word_t      data_sram_wdata;
    word_t      data_sram_rdata;

    word_t data_mem [64];
    word_t preload  [64];
    word_t prev_fetch;
    int    since_reset;
    int    store_count;
    int    value_errors;
    int    other_errors;

    // galois form shifts right and folds the taps back in
    function automatic word_t lfsr_next(input word_t state);
        word_t next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ LFSR_TAPS;
        end
        return next;
    endfunction

    function automatic word_t program_word(input word_t addr);
        word_t offset;
        offset = addr - RESET_PC;
        if (offset[1:0] == 2'b00 && offset[31:2] < PROG_WORDS) begin
            return PROG_IMAGE[offset[31:2]];
        end
        return '0;
    endfunction

    function automatic string store_test_name(input int idx);
        if (idx < 5) begin
            return "alu_forwarding";
        end
        if (idx == 5) begin
            return "load_use";
        end
        if (idx == 6) begin
            return "beq_delay_slot";
        end
        if (idx == 7) begin
            return "bne_delay_slot";
        end
        return "after_not_taken";
    endfunction

    task automatic check_store(input word_t addr, input word_t data);
        word_t exp_data;
        string name;
        if (store_count >= EXP_STORES) begin
            other_errors++;
            $display("unexpected extra store of %h to address %h", data, addr);
        end else begin
            name     = store_test_name(store_count);
            exp_data = EXP_DATA[store_count];
            // load-based entries add the preloaded word
            if (EXP_LOAD_IDX[store_count] >= 0) begin
                exp_data = exp_data + preload[EXP_LOAD_IDX[store_count]];
            end
            assert (addr == EXP_ADDR[store_count]) else begin
                value_errors++;
                $display("** Error %s: address expected %h, actual %h",
                         name, EXP_ADDR[store_count], addr);
            end
            assert (data == exp_data) else begin
                value_errors++;
                $display("** Error %s: data expected %h, actual %h", name, exp_data, data);
            end
        end
        store_count++;
    endtask

    mips_top #(
        .RESET_PC(RESET_PC)
    ) mips_top_inst (
        .clk_i(clk), .rst_n_i(rst_n),
        .inst_sram_addr_o(inst_sram_addr), .inst_sram_rdata_i(inst_sram_rdata),
        .data_sram_wen_o(data_sram_wen), .data_sram_addr_o(data_sram_addr),
        .data_sram_wdata_o(data_sram_wdata), .data_sram_rdata_i(data_sram_rdata)
    );

    // both srams answer in the same cycle
    assign inst_sram_rdata = program_word(inst_sram_addr);
    assign data_sram_rdata = data_mem[data_sram_addr[7:2]];

    always @(posedge clk) begin
        if (rst_n && data_sram_wen == WEN_ALL) begin
            check_store(data_sram_addr, data_sram_wdata);
            data_mem[data_sram_addr[7:2]] <= data_sram_wdata;
        end
        if (!rst_n) begin
            since_reset <= 0;
        end else if (since_reset < 1000) begin
            since_reset <= since_reset + 1;
        end
        prev_fetch <= inst_sram_addr;
    end

    reset_pc_check: assert property (@(posedge clk) !rst_n |=> inst_sram_addr == RESET_PC)
        else begin
            value_errors++;
            $display("** Error reset_pc: expected %h, actual %h",
                     RESET_PC, $sampled(inst_sram_addr));
        end

    reset_wen_check: assert property (@(posedge clk) !rst_n |=> data_sram_wen == WEN_NONE)
        else begin
            value_errors++;
            $display("** Error reset_wen: expected %b, actual %b",
                     WEN_NONE, $sampled(data_sram_wen));
        end

    // straight-line code at the start has no stall or branch
    fetch_advance_check: assert property (@(posedge clk)
        since_reset >= 1 && since_reset < ADVANCE_SPAN |-> inst_sram_addr == prev_fetch + 32'd4)
        else begin
            value_errors++;
            $display("** Error fetch_advance: expected %h, actual %h",
                     $sampled(prev_fetch) + 32'd4, $sampled(inst_sram_addr));
        end

    store_form_check: assert property (@(posedge clk) disable iff (!rst_n)
        data_sram_wen == WEN_NONE || (data_sram_wen == WEN_ALL && data_sram_addr[1:0] == 2'b00))
        else begin
            value_errors++;
            $display("** Error store_form: expected mask 0000 or 1111 aligned, actual %b at %h",
                     $sampled(data_sram_wen), $sampled(data_sram_addr));
        end

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        word_t lfsr;
        word_t fill;
        int    w;
        int    b;
        int    waited;
        rst_n        = 1'b0;
        store_count  = 0;
        value_errors = 0;
        other_errors = 0;
        lfsr         = 32'd70;
        for (w = 0; w < 64; w++) begin
            fill = '0;
            for (b = 0; b < 32; b++) begin
                lfsr = lfsr_next(lfsr);
                fill = {fill[30:0], lfsr[0]};
            end
            data_mem[w] <= fill;
            preload[w]  = fill;
        end

        repeat (3) @(posedge clk);
        #2 rst_n = 1'b1;

        waited = 0;
        while (store_count < EXP_STORES && waited < STORE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (store_count < EXP_STORES) begin
            other_errors++;
            $display("timed out after %0d cycles with %0d of %0d stores seen",
                     waited, store_count, EXP_STORES);
        end

        // program ends in a tight loop so any later store is an error
        for (waited = 0; waited < DRAIN_CYCLES; waited++) begin
            @(negedge clk);
        end

        $display("errors: %0d value, %0d other, %0d of %0d stores seen",
                 value_errors, other_errors, store_count, EXP_STORES);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verilog/mips_decode.sv */
`timescale 1ns/1ps

module mips_decode
    import mips_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  word_t     instr_i,
    input  word_t     pc_i,
    output reg_addr_t rs_addr_o,
    output reg_addr_t rt_addr_o,
    input  word_t     rs_data_i,
    input  word_t     rt_data_i,
    input  logic      ex_wr_en_i,
    input  reg_addr_t ex_wr_addr_i,
    input  logic      ex_is_load_i,
    input  word_t     ex_result_i,
    input  logic      mem_wr_en_i,
    input  reg_addr_t mem_wr_addr_i,
    input  word_t     mem_result_i,
    output logic      stall_o,
    output logic      branch_taken_o,
    output word_t     branch_target_o,
    output alu_op_e   ex_alu_op_o,
    output word_t     ex_op_a_o,
    output word_t     ex_op_b_o,
    output word_t     ex_store_data_o,
    output logic      ex_wr_en_o,
    output reg_addr_t ex_wr_addr_o,
    output logic      ex_is_load_o,
    output logic      ex_is_store_o
);

    opcode_e     opcode;
    funct_e      funct;
    reg_addr_t   rd;
    logic [15:0] imm;
    word_t       imm_sext;
    word_t       imm_zext;
    alu_op_e     alu_op;
    word_t       imm_val;
    logic        use_imm;
    logic        use_rt;
    logic        wr_en;
    logic        dec_wr_en;
    reg_addr_t   wr_addr;
    logic        is_load;
    logic        is_store;
    logic        is_beq;
    logic        is_bne;
    logic        known_op;
    word_t       rs_val;
    word_t       rt_val;
    logic        operands_eq;

    assign opcode    = opcode_e'(instr_i[31:26]);
    assign funct     = funct_e'(instr_i[5:0]);
    assign rs_addr_o = instr_i[25:21];
    assign rt_addr_o = instr_i[20:16];
    assign rd        = instr_i[15:11];
    assign imm       = instr_i[15:0];
    assign imm_sext  = {{16{imm[15]}}, imm};
    assign imm_zext  = {16'h0000, imm};

    always_comb begin
        alu_op   = ALU_ADD;
        imm_val  = imm_sext;
        use_imm  = 1'b1;
        use_rt   = 1'b0;
        wr_en    = 1'b0;
        wr_addr  = rt_addr_o;
        is_load  = 1'b0;
        is_store = 1'b0;
        is_beq   = 1'b0;
        is_bne   = 1'b0;
        known_op = 1'b1;
        case (opcode)
            OP_SPECIAL: begin
                use_imm = 1'b0;
                use_rt  = 1'b1;
                wr_en   = 1'b1;
                wr_addr = rd;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: begin
                        wr_en    = 1'b0;
                        known_op = 1'b0;
                    end
                endcase
            end
            OP_ADDIU: wr_en = 1'b1;
            OP_ORI: begin
                alu_op  = ALU_OR;
                imm_val = imm_zext;
                wr_en   = 1'b1;
            end
            OP_LUI: begin
                alu_op  = ALU_LUI;
                imm_val = imm_zext;
                wr_en   = 1'b1;
            end
            OP_LW: begin
                wr_en   = 1'b1;
                is_load = 1'b1;
            end
            OP_SW: begin
                use_rt   = 1'b1;
                is_store = 1'b1;
            end
            OP_BEQ: begin
                use_rt = 1'b1;
                is_beq = 1'b1;
            end
            OP_BNE: begin
                use_rt = 1'b1;
                is_bne = 1'b1;
            end
            default: known_op = 1'b0;
        endcase
    end

    // writes to $zero are dropped here so forwarding never matches them
    assign dec_wr_en = wr_en && (wr_addr != '0);

    // youngest producer wins
    assign rs_val = (ex_wr_en_i && ex_wr_addr_i == rs_addr_o) ? ex_result_i :
                    (mem_wr_en_i && mem_wr_addr_i == rs_addr_o) ? mem_result_i : rs_data_i;
    assign rt_val = (ex_wr_en_i && ex_wr_addr_i == rt_addr_o) ? ex_result_i :
                    (mem_wr_en_i && mem_wr_addr_i == rt_addr_o) ? mem_result_i : rt_data_i;

    // load data only exists one stage later
    assign stall_o = ex_is_load_i && ex_wr_en_i &&
                     ((ex_wr_addr_i == rs_addr_o) || (use_rt && ex_wr_addr_i == rt_addr_o));

    assign operands_eq     = (rs_val == rt_val);
    assign branch_taken_o  = !stall_o && ((is_beq && operands_eq) || (is_bne && !operands_eq));
    assign branch_target_o = pc_i + 32'd4 + {{14{imm[15]}}, imm, 2'b00};

    // bubble on stall
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || stall_o) begin
            ex_wr_en_o    <= 1'b0;
            ex_is_load_o  <= 1'b0;
            ex_is_store_o <= 1'b0;
        end else begin
            ex_wr_en_o    <= dec_wr_en;
            ex_is_load_o  <= is_load;
            ex_is_store_o <= is_store;
        end
    end

    always_ff @(posedge clk_i) begin
        ex_alu_op_o     <= alu_op;
        ex_op_a_o       <= rs_val;
        ex_op_b_o       <= use_imm ? imm_val : rt_val;
        ex_store_data_o <= rt_val;
        ex_wr_addr_o    <= wr_addr;
    end

    // unrecognised instructions travel on as bubbles
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !known_op |=> !ex_wr_en_o);

endmodule

/* verilog/mips_execute.sv */
`timescale 1ns/1ps

module mips_execute
    import mips_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  alu_op_e   alu_op_i,
    input  word_t     op_a_i,
    input  word_t     op_b_i,
    input  word_t     store_data_i,
    input  logic      wr_en_i,
    input  reg_addr_t wr_addr_i,
    input  logic      is_load_i,
    input  logic      is_store_i,
    output word_t     result_o,
    output word_t     mem_addr_o,
    output word_t     mem_store_data_o,
    output logic      mem_wr_en_o,
    output reg_addr_t mem_wr_addr_o,
    output logic      mem_is_load_o,
    output logic      mem_is_store_o
);

    always_comb begin
        case (alu_op_i)
            ALU_ADD: result_o = op_a_i + op_b_i;
            ALU_SUB: result_o = op_a_i - op_b_i;
            ALU_AND: result_o = op_a_i & op_b_i;
            ALU_OR:  result_o = op_a_i | op_b_i;
            // signed compare
            ALU_SLT: result_o = word_t'($signed(op_a_i) < $signed(op_b_i));
            ALU_LUI: result_o = {op_b_i[15:0], 16'h0000};
            default: result_o = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mem_wr_en_o    <= 1'b0;
            mem_is_load_o  <= 1'b0;
            mem_is_store_o <= 1'b0;
        end else begin
            mem_wr_en_o    <= wr_en_i;
            mem_is_load_o  <= is_load_i;
            mem_is_store_o <= is_store_i;
        end
    end

    // result doubles as the memory address for loads and stores
    always_ff @(posedge clk_i) begin
        mem_addr_o       <= result_o;
        mem_store_data_o <= store_data_i;
        mem_wr_addr_o    <= wr_addr_i;
    end

endmodule

/* verilog/mips_fetch.sv */
`timescale 1ns/1ps

module mips_fetch
    import mips_pkg::*;
#(
    parameter word_t RESET_PC = 32'hBFC0_0000
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  stall_i,
    input  logic  branch_taken_i,
    input  word_t branch_target_i,
    input  word_t inst_sram_rdata_i,
    output word_t pc_o,
    output word_t id_instr_o,
    output word_t id_pc_o
);

    // the delay slot is already in flight when decode redirects
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_o <= RESET_PC;
        end else if (!stall_i) begin
            pc_o <= branch_taken_i ? branch_target_i : pc_o + 32'd4;
        end
    end

    // an all-zero word decodes as a nop
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            id_instr_o <= '0;
        end else if (!stall_i) begin
            id_instr_o <= inst_sram_rdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            id_pc_o <= pc_o;
        end
    end

    // redirect targets keep the pc word-aligned
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        branch_taken_i && !stall_i |=> pc_o[1:0] == 2'b00);

endmodule

/* verilog/mips_memory.sv */
`timescale 1ns/1ps

module mips_memory
    import mips_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  word_t      addr_i,
    input  word_t      store_data_i,
    input  logic       wr_en_i,
    input  reg_addr_t  wr_addr_i,
    input  logic       is_load_i,
    input  logic       is_store_i,
    output logic [3:0] data_sram_wen_o,
    output word_t      data_sram_addr_o,
    output word_t      data_sram_wdata_o,
    input  word_t      data_sram_rdata_i,
    output word_t      result_o,
    output logic       wb_wr_en_o,
    output reg_addr_t  wb_wr_addr_o,
    output word_t      wb_wr_data_o
);

    assign data_sram_wen_o   = is_store_i ? WEN_ALL : WEN_NONE;
    assign data_sram_addr_o  = addr_i;
    assign data_sram_wdata_o = store_data_i;

    // read data is valid in the same cycle
    assign result_o = is_load_i ? data_sram_rdata_i : addr_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_wr_en_o <= 1'b0;
        end else begin
            wb_wr_en_o <= wr_en_i;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_wr_addr_o <= wr_addr_i;
        wb_wr_data_o <= result_o;
    end

    // no sub-word accesses in this core
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (is_load_i || is_store_i) |-> addr_i[1:0] == 2'b00);

endmodule

/* verilog/mips_pkg.sv */
package mips_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // primary opcode field in instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // function field of SPECIAL in instr[5:0]
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    // data sram lane masks for word access only
    localparam logic [3:0] WEN_ALL  = 4'b1111;
    localparam logic [3:0] WEN_NONE = 4'b0000;

endpackage

/* verilog/mips_regfile.sv */
`timescale 1ns/1ps

module mips_regfile
    import mips_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  reg_addr_t rs_addr_i,
    input  reg_addr_t rt_addr_i,
    output word_t     rs_data_o,
    output word_t     rt_data_o,
    input  logic      wr_en_i,
    input  reg_addr_t wr_addr_i,
    input  word_t     wr_data_i
);

    word_t regs_q [32];

    // entry zero is never written
    always_ff @(posedge clk_i) begin
        if (rst_n_i && wr_en_i && wr_addr_i != '0) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    // write-first so write-back and decode can share a cycle
    assign rs_data_o = (rs_addr_i == '0) ? '0 :
                       (wr_en_i && wr_addr_i == rs_addr_i) ? wr_data_i : regs_q[rs_addr_i];
    assign rt_data_o = (rt_addr_i == '0) ? '0 :
                       (wr_en_i && wr_addr_i == rt_addr_i) ? wr_data_i : regs_q[rt_addr_i];

    // $zero stays zero even while write-back targets it
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rs_addr_i == '0 |-> rs_data_o == '0) and (rt_addr_i == '0 |-> rt_data_o == '0));

endmodule

/* verilog/mips_top.sv */
`timescale 1ns/1ps

module mips_top
    import mips_pkg::*;
#(
    parameter word_t RESET_PC = 32'hBFC0_0000
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    output word_t      inst_sram_addr_o,
    input  word_t      inst_sram_rdata_i,
    output logic [3:0] data_sram_wen_o,
    output word_t      data_sram_addr_o,
    output word_t      data_sram_wdata_o,
    input  word_t      data_sram_rdata_i
);

    logic      stall;
    logic      branch_taken;
    word_t     branch_target;
    word_t     id_instr;
    word_t     id_pc;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;
    alu_op_e   ex_alu_op;
    word_t     ex_op_a;
    word_t     ex_op_b;
    word_t     ex_store_data;
    logic      ex_wr_en;
    reg_addr_t ex_wr_addr;
    logic      ex_is_load;
    logic      ex_is_store;
    word_t     ex_result;
    word_t     mem_addr;
    word_t     mem_store_data;
    logic      mem_wr_en;
    reg_addr_t mem_wr_addr;
    logic      mem_is_load;
    logic      mem_is_store;
    word_t     mem_result;
    logic      wb_wr_en;
    reg_addr_t wb_wr_addr;
    word_t     wb_wr_data;

    mips_fetch #(
        .RESET_PC(RESET_PC)
    ) mips_fetch_inst (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .stall_i(stall),
        .branch_taken_i(branch_taken), .branch_target_i(branch_target),
        .inst_sram_rdata_i(inst_sram_rdata_i), .pc_o(inst_sram_addr_o),
        .id_instr_o(id_instr), .id_pc_o(id_pc)
    );

    mips_regfile mips_regfile_inst (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .rs_addr_i(rs_addr), .rt_addr_i(rt_addr),
        .rs_data_o(rs_data), .rt_data_o(rt_data),
        .wr_en_i(wb_wr_en), .wr_addr_i(wb_wr_addr), .wr_data_i(wb_wr_data)
    );

    // forwarding taps the execute inputs and the memory-stage result
    mips_decode mips_decode_inst (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .instr_i(id_instr), .pc_i(id_pc),
        .rs_addr_o(rs_addr), .rt_addr_o(rt_addr), .rs_data_i(rs_data), .rt_data_i(rt_data),
        .ex_wr_en_i(ex_wr_en), .ex_wr_addr_i(ex_wr_addr),
        .ex_is_load_i(ex_is_load), .ex_result_i(ex_result),
        .mem_wr_en_i(mem_wr_en), .mem_wr_addr_i(mem_wr_addr), .mem_result_i(mem_result),
        .stall_o(stall), .branch_taken_o(branch_taken), .branch_target_o(branch_target),
        .ex_alu_op_o(ex_alu_op), .ex_op_a_o(ex_op_a), .ex_op_b_o(ex_op_b),
        .ex_store_data_o(ex_store_data), .ex_wr_en_o(ex_wr_en), .ex_wr_addr_o(ex_wr_addr),
        .ex_is_load_o(ex_is_load), .ex_is_store_o(ex_is_store)
    );

    mips_execute mips_execute_inst (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .alu_op_i(ex_alu_op),
        .op_a_i(ex_op_a), .op_b_i(ex_op_b), .store_data_i(ex_store_data),
        .wr_en_i(ex_wr_en), .wr_addr_i(ex_wr_addr),
        .is_load_i(ex_is_load), .is_store_i(ex_is_store), .result_o(ex_result),
        .mem_addr_o(mem_addr), .mem_store_data_o(mem_store_data),
        .mem_wr_en_o(mem_wr_en), .mem_wr_addr_o(mem_wr_addr),
        .mem_is_load_o(mem_is_load), .mem_is_store_o(mem_is_store)
    );

    mips_memory mips_memory_inst (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .addr_i(mem_addr), .store_data_i(mem_store_data),
        .wr_en_i(mem_wr_en), .wr_addr_i(mem_wr_addr),
        .is_load_i(mem_is_load), .is_store_i(mem_is_store),
        .data_sram_wen_o(data_sram_wen_o), .data_sram_addr_o(data_sram_addr_o),
        .data_sram_wdata_o(data_sram_wdata_o), .data_sram_rdata_i(data_sram_rdata_i),
        .result_o(mem_result),
        .wb_wr_en_o(wb_wr_en), .wb_wr_addr_o(wb_wr_addr), .wb_wr_data_o(wb_wr_data)
    );

endmodule
